//--- verilog/cache_pkg.sv
package cache_pkg;

	// Address geometry
	localparam int TAG_W    = 5;
	localparam int INDEX_W  = 8;
	localparam int OFFSET_W = 3;

	localparam int LINES = 256;

	// Line transfer
	localparam int MEM_LATENCY = 2;	// Read edges in main memory
	localparam int BEATS       = 4;	// Words per line
	localparam int FILL_BEATS  = BEATS + MEM_LATENCY;

	typedef enum logic [2:0] {
		IDLE      = 3'd0,
		COMPARE   = 3'd1,
		WRITEBACK = 3'd2,
		FILL      = 3'd3,
		DONE      = 3'd4
	} state_t;

	// Byte address seen flat or split into fields
	typedef union packed {
		logic [15:0] word;
		struct packed {
			logic [TAG_W-1:0]    tag;
			logic [INDEX_W-1:0]  index;
			logic [OFFSET_W-1:0] offset;
		} f;
	} cache_addr_u;

endpackage

//--- verilog/beat_counter.sv
`timescale 1ns/1ps

module beat_counter (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           cnt_start,
	input  logic                           cnt_fill,
	output logic [cache_pkg::OFFSET_W-1:0] mem_offset,
	output logic [cache_pkg::OFFSET_W-1:0] cache_offset,
	output logic                           mem_beat,
	output logic                           cache_beat,
	output logic                           last
);
	import cache_pkg::*;

	logic [2:0] count;
	logic [2:0] cache_count;	// Lags by the memory latency in a fill
	logic       busy;
	logic       fill_mode;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			count     <= 3'd0;
			fill_mode <= 1'b0;
		end else if (cnt_start) begin
			busy      <= 1'b1;
			count     <= 3'd0;
			fill_mode <= cnt_fill;
		end else if (last) begin
			busy <= 1'b0;
		end else if (busy) begin
			count <= count + 3'd1;
		end
	end

	assign cache_count = fill_mode ? count - 3'(MEM_LATENCY) : count;

	assign mem_offset   = {count[1:0], 1'b0};
	assign cache_offset = {cache_count[1:0], 1'b0};

	assign mem_beat   = busy && (count < 3'(BEATS));
	assign cache_beat = busy && (fill_mode ? count >= 3'(MEM_LATENCY) : count < 3'(BEATS));
	assign last       = busy && (count == (fill_mode ? 3'(FILL_BEATS - 1) : 3'(BEATS - 1)));

endmodule

//--- verilog/cache_array.sv
`timescale 1ns/1ps

module cache_array (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [cache_pkg::INDEX_W-1:0]  index,
	input  logic [cache_pkg::OFFSET_W-1:0] offset,
	input  logic [cache_pkg::TAG_W-1:0]    tag_in,
	input  logic [15:0]                    cache_wdata,
	input  logic                           enable,
	input  logic                           comp,
	input  logic                           write,
	output logic [15:0]                    cache_rdata,
	output logic [cache_pkg::TAG_W-1:0]    tag_out,
	output logic                           hit,
	output logic                           valid,
	output logic                           dirty
);
	import cache_pkg::*;

	cache_addr_u acc;	// Access address
	logic [TAG_W-1:0] tag_mem [0:LINES-1];
	logic [15:0]      data_mem [0:LINES*BEATS-1];
	logic [LINES-1:0] valid_bits;
	logic [LINES-1:0] dirty_bits;
	logic [INDEX_W+OFFSET_W-2:0] word_sel;
	logic match;
	logic wr_hit;
	logic wr_fill;

	assign acc.word = {tag_in, index, offset};
	assign word_sel = {acc.f.index, acc.f.offset[OFFSET_W-1:1]};	// Drop byte bit

	// Combinational read side
	assign tag_out     = tag_mem[acc.f.index];
	assign valid       = valid_bits[acc.f.index];
	assign dirty       = dirty_bits[acc.f.index];
	assign cache_rdata = data_mem[word_sel];

	assign match = (tag_out == acc.f.tag);
	assign hit   = enable && comp && valid && match;

	assign wr_hit  = hit && write;
	assign wr_fill = enable && !comp && write;	// Access mode write

	always_ff @(posedge clk) begin
		if (wr_hit || wr_fill)
			data_mem[word_sel] <= cache_wdata;
		if (wr_fill)
			tag_mem[acc.f.index] <= acc.f.tag;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (wr_fill) begin
			valid_bits[acc.f.index] <= 1'b1;
			dirty_bits[acc.f.index] <= 1'b0;	// Fresh from memory
		end else if (wr_hit) begin
			dirty_bits[acc.f.index] <= 1'b1;
		end
	end

endmodule

//--- verilog/main_memory.sv
`timescale 1ns/1ps

module main_memory (
	input  logic                   clk,
	input  cache_pkg::cache_addr_u mem_addr,
	input  logic                   mem_rd,
	input  logic                   mem_wr,
	input  logic [15:0]            mem_wdata,
	output logic [15:0]            mem_rdata
);
	import cache_pkg::*;

	logic [15:0] mem [0:2**(TAG_W+INDEX_W+OFFSET_W-1)-1];
	logic [TAG_W+INDEX_W+OFFSET_W-2:0] word_addr;
	logic [15:0] rd_stage;	// First read stage

	assign word_addr = mem_addr.word[15:1];

	initial begin
		for (int i = 0; i < 2**(TAG_W+INDEX_W+OFFSET_W-1); i++)
			mem[i] = 16'h0000;
	end

	always_ff @(posedge clk) begin
		if (mem_wr)
			mem[word_addr] <= mem_wdata;
	end

	// Read data lands two edges after the request
	always_ff @(posedge clk) begin
		if (mem_rd)
			rd_stage <= mem[word_addr];
		mem_rdata <= rd_stage;
	end

endmodule

//--- verilog/cache_fsm.sv
`timescale 1ns/1ps

module cache_fsm (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           rd,
	input  logic                           wr,
	input  logic [15:0]                    addr,
	input  logic [15:0]                    wdata,
	input  logic                           hit,
	input  logic                           valid,
	input  logic                           dirty,
	input  logic [cache_pkg::TAG_W-1:0]    tag_out,
	input  logic [15:0]                    cache_rdata,
	input  logic [15:0]                    mem_rdata,
	input  logic                           mem_beat,
	input  logic                           cache_beat,
	input  logic                           last,
	input  logic [cache_pkg::OFFSET_W-1:0] mem_offset,
	input  logic [cache_pkg::OFFSET_W-1:0] cache_offset,
	output logic                           cnt_start,
	output logic                           cnt_fill,
	output logic [cache_pkg::INDEX_W-1:0]  index,
	output logic [cache_pkg::OFFSET_W-1:0] offset,
	output logic [cache_pkg::TAG_W-1:0]    tag_in,
	output logic [15:0]                    cache_wdata,
	output logic                           enable,
	output logic                           comp,
	output logic                           write,
	output cache_pkg::cache_addr_u         mem_addr,
	output logic                           mem_rd,
	output logic                           mem_wr,
	output logic                           done,
	output logic                           stall,
	output logic                           err,
	output logic [15:0]                    rdata
);
	import cache_pkg::*;

	state_t      state;
	state_t      next_state;
	cache_addr_u req_addr;	// Latched request
	logic [15:0] req_wdata;
	logic        req_wr;
	logic        req_ok;

	assign req_ok = (state == IDLE) && (rd ^ wr);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			err   <= 1'b0;
		end else begin
			state <= next_state;
			err   <= (state == IDLE) && rd && wr && !err;	// One cycle only
		end
	end

	always_ff @(posedge clk) begin
		if (req_ok) begin
			req_addr.word <= addr;
			req_wdata     <= wdata;
			req_wr        <= wr;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
		IDLE: if (req_ok) next_state = COMPARE;
		COMPARE: begin
			if (hit)
				next_state = DONE;
			else if (valid && dirty)
				next_state = WRITEBACK;	// Victim must go out first
			else
				next_state = FILL;
		end
		WRITEBACK: if (last) next_state = FILL;
		FILL: if (last) next_state = COMPARE;	// Compare again on the new line
		DONE: next_state = IDLE;
		default: next_state = IDLE;
		endcase
	end

	// Array, memory and counter controls
	always_comb begin
		enable      = 1'b0;
		comp        = 1'b0;
		write       = 1'b0;
		offset      = req_addr.f.offset;
		cache_wdata = req_wdata;
		mem_rd      = 1'b0;
		mem_wr      = 1'b0;
		cnt_start   = 1'b0;
		cnt_fill    = 1'b0;
		case (state)
		COMPARE: begin
			enable    = 1'b1;
			comp      = 1'b1;
			write     = req_wr;
			cnt_start = !hit;
			cnt_fill  = !(valid && dirty);
		end
		WRITEBACK: begin
			enable    = 1'b1;
			offset    = cache_offset;
			mem_wr    = mem_beat;
			cnt_start = last;	// Chain straight into the fill
			cnt_fill  = 1'b1;
		end
		FILL: begin
			enable      = 1'b1;
			offset      = cache_offset;
			write       = cache_beat;
			cache_wdata = mem_rdata;
			mem_rd      = mem_beat;
		end
		DONE: enable = 1'b1;	// Read back the requested word
		default: ;
		endcase
	end

	assign index  = req_addr.f.index;
	assign tag_in = req_addr.f.tag;

	always_comb begin
		mem_addr.f.tag    = (state == WRITEBACK) ? tag_out : req_addr.f.tag;
		mem_addr.f.index  = req_addr.f.index;
		mem_addr.f.offset = mem_offset;
	end

	assign done  = (state == DONE);
	assign stall = (state == COMPARE) || (state == WRITEBACK) || (state == FILL);
	assign rdata = cache_rdata;	// Holds the new word after a write

endmodule

//--- verilog/mem_system.sv
`timescale 1ns/1ps

module mem_system (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        rd,
	input  logic        wr,
	input  logic [15:0] addr,
	input  logic [15:0] wdata,
	output logic [15:0] rdata,
	output logic        done,
	output logic        stall,
	output logic        err
);
	import cache_pkg::*;

	logic                cnt_start;
	logic                cnt_fill;
	logic [OFFSET_W-1:0] mem_offset;
	logic [OFFSET_W-1:0] cache_offset;
	logic                mem_beat;
	logic                cache_beat;
	logic                last;
	logic [INDEX_W-1:0]  index;
	logic [OFFSET_W-1:0] offset;
	logic [TAG_W-1:0]    tag_in;
	logic [TAG_W-1:0]    tag_out;
	logic [15:0]         cache_wdata;
	logic [15:0]         cache_rdata;
	logic                enable;
	logic                comp;
	logic                write;
	logic                hit;
	logic                valid;
	logic                dirty;
	cache_addr_u         mem_addr;
	logic                mem_rd;
	logic                mem_wr;
	logic [15:0]         mem_rdata;

	cache_fsm fsm_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.rd           (rd),
		.wr           (wr),
		.addr         (addr),
		.wdata        (wdata),
		.hit          (hit),
		.valid        (valid),
		.dirty        (dirty),
		.tag_out      (tag_out),
		.cache_rdata  (cache_rdata),
		.mem_rdata    (mem_rdata),
		.mem_beat     (mem_beat),
		.cache_beat   (cache_beat),
		.last         (last),
		.mem_offset   (mem_offset),
		.cache_offset (cache_offset),
		.cnt_start    (cnt_start),
		.cnt_fill     (cnt_fill),
		.index        (index),
		.offset       (offset),
		.tag_in       (tag_in),
		.cache_wdata  (cache_wdata),
		.enable       (enable),
		.comp         (comp),
		.write        (write),
		.mem_addr     (mem_addr),
		.mem_rd       (mem_rd),
		.mem_wr       (mem_wr),
		.done         (done),
		.stall        (stall),
		.err          (err),
		.rdata        (rdata)
	);

	beat_counter cnt_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.cnt_start    (cnt_start),
		.cnt_fill     (cnt_fill),
		.mem_offset   (mem_offset),
		.cache_offset (cache_offset),
		.mem_beat     (mem_beat),
		.cache_beat   (cache_beat),
		.last         (last)
	);

	cache_array array_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.index       (index),
		.offset      (offset),
		.tag_in      (tag_in),
		.cache_wdata (cache_wdata),
		.enable      (enable),
		.comp        (comp),
		.write       (write),
		.cache_rdata (cache_rdata),
		.tag_out     (tag_out),
		.hit         (hit),
		.valid       (valid),
		.dirty       (dirty)
	);

	// Writeback data comes straight off the array read port
	main_memory mem_i (
		.clk       (clk),
		.mem_addr  (mem_addr),
		.mem_rd    (mem_rd),
		.mem_wr    (mem_wr),
		.mem_wdata (cache_rdata),
		.mem_rdata (mem_rdata)
	);

endmodule

//--- bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
	output logic clk
);
	localparam real HALF_PERIOD = 2.0;	// 4 ns period

	initial clk = 1'b0;

	always #(HALF_PERIOD) clk = ~clk;

endmodule

//--- bench/mem_system_asserts.sv
`timescale 1ns/1ps

module mem_system_asserts (
	input logic              clk,
	input logic              rst_n,
	input cache_pkg::state_t state,
	input logic              done,
	input logic              stall,
	input logic              err,
	input logic              mem_rd,
	input logic              mem_wr
);
	import cache_pkg::*;

	a_done_single: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else begin
			$error("done high for more than one cycle");
			mem_system_tb.assert_fails++;
		end

	a_stall_done: assert property (@(posedge clk) disable iff (!rst_n) !(stall && done))
		else begin
			$error("stall and done high together");
			mem_system_tb.assert_fails++;
		end

	a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n) !(mem_rd && mem_wr))
		else begin
			$error("memory read and write issued together");
			mem_system_tb.assert_fails++;
		end

	// err is registered, so the state one edge back must be IDLE
	a_err_idle: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(err) |-> $past(state) == IDLE)
		else begin
			$error("err raised outside IDLE");
			mem_system_tb.assert_fails++;
		end

endmodule

//--- bench/mem_system_tb.sv
`timescale 1ns/1ps

module mem_system_tb;

	localparam int RST_CYCLES     = 4;
	localparam int CYCLES_PER_REQ = 20;
	localparam int MAX_WAIT       = 20;	// Edges allowed for one request

	logic        clk;
	logic        rst_n;
	logic        rd;
	logic        wr;
	logic [15:0] addr;
	logic [15:0] wdata;
	logic [15:0] rdata;
	logic        done;
	logic        stall;
	logic        err;

	int          errors;
	int          checks;
	int          assert_fails;
	int          n_req;
	bit          loaded;
	logic [15:0] lfsr;

	logic [7:0]  op_q[$];
	logic [15:0] addr_q[$];
	logic [15:0] wdata_q[$];
	logic [15:0] exp_q[$];
	int          lat_q[$];

	clock_gen clk_i (.clk(clk));

	mem_system dut_i (
		.clk   (clk),
		.rst_n (rst_n),
		.rd    (rd),
		.wr    (wr),
		.addr  (addr),
		.wdata (wdata),
		.rdata (rdata),
		.done  (done),
		.stall (stall),
		.err   (err)
	);

	bind cache_fsm mem_system_asserts asserts_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.state  (state),
		.done   (done),
		.stall  (stall),
		.err    (err),
		.mem_rd (mem_rd),
		.mem_wr (mem_wr)
	);

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = (s >> 1) ^ (s[0] ? 16'hb400 : 16'h0000);
	endfunction

	task automatic load_requests;
		int          fd;
		int          n;
		string       line;
		logic [7:0]  op;
		logic [15:0] a;
		logic [15:0] d;
		logic [15:0] e;
		int          lat;
		fd = $fopen("bench/mem_system_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the request file bench/mem_system_input.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd)) begin
					op = " ";
					n = $sscanf(line, "%c %h %h %h %d", op, a, d, e, lat);
					if (n == 5 && (op == "R" || op == "W" || op == "B")) begin
						op_q.push_back(op);
						addr_q.push_back(a);
						wdata_q.push_back(d);
						exp_q.push_back(e);
						lat_q.push_back(lat);
					end else if (n >= 1 && op != "#" && op != "\n" && op != " ") begin
						$display("Malformed request line: %s", line);
						errors++;
					end
				end
			end
			$fclose(fd);
		end
		n_req = op_q.size();
	endtask

	// Gap of 0 to 3 idle cycles from two LFSR bits
	task automatic idle_gap;
		logic [1:0] gap;
		gap = 2'b00;
		repeat (2) begin
			gap  = {gap[0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic run_request(input int idx);
		logic [7:0] op;
		int         edges;
		bit         seen;
		bit         ok;
		op    = op_q[idx];
		ok    = 1'b1;
		seen  = 1'b0;
		addr  = addr_q[idx];
		wdata = wdata_q[idx];
		rd    = (op == "R") || (op == "B");
		wr    = (op == "W") || (op == "B");
		@(posedge clk);
		edges = 1;	// Sampling edge
		#1;
		rd = 1'b0;
		wr = 1'b0;
		if (op == "B") begin
			@(negedge clk);
			checks++;
			if (err !== 1'b1) begin
				$display("CHECK FAILED test %0d err: expected 0x1 got 0x%0h", idx, err);
				errors++;
				ok = 1'b0;
			end
			repeat (3) begin
				checks++;
				if (done !== 1'b0) begin
					$display("CHECK FAILED test %0d done: expected 0x0 got 0x%0h", idx, done);
					errors++;
					ok = 1'b0;
				end
				@(negedge clk);
				checks++;
				if (err !== 1'b0) begin
					$display("CHECK FAILED test %0d err: expected 0x0 got 0x%0h", idx, err);
					errors++;
					ok = 1'b0;
				end
			end
		end else begin
			while (!seen && edges <= MAX_WAIT) begin
				@(negedge clk);
				if (done === 1'b1) begin
					seen = 1'b1;
				end else begin
					checks++;
					if (stall !== 1'b1) begin
						$display("CHECK FAILED test %0d stall: expected 0x1 got 0x%0h", idx, stall);
						errors++;
						ok = 1'b0;
					end
					@(posedge clk);
					edges++;
				end
			end
			if (!seen) begin
				$display("Test %0d: done never came within %0d cycles", idx, MAX_WAIT);
				errors++;
				ok = 1'b0;
			end else begin
				checks++;
				if (edges != lat_q[idx]) begin
					$display("CHECK FAILED test %0d latency: expected 0x%0h got 0x%0h",
						idx, lat_q[idx], edges);
					errors++;
					ok = 1'b0;
				end
				checks++;
				if (rdata !== exp_q[idx]) begin
					$display("CHECK FAILED test %0d rdata: expected 0x%04h got 0x%04h",
						idx, exp_q[idx], rdata);
					errors++;
					ok = 1'b0;
				end
			end
		end
		@(posedge clk);
		#1;
		$display("Test %0d: %c addr 0x%04h edges %0d %s", idx, op, addr_q[idx], edges,
			ok ? "ok" : "failed");
	endtask

	initial begin
		rst_n        = 1'b0;
		rd           = 1'b0;
		wr           = 1'b0;
		addr         = 16'h0000;
		wdata        = 16'h0000;
		errors       = 0;
		checks       = 0;
		assert_fails = 0;
		n_req        = 0;
		lfsr         = 16'd46001;
		loaded       = 1'b0;
		load_requests();
		loaded = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int i = 0; i < n_req; i++) begin
			idle_gap();
			run_request(i);
		end
		$display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
			n_req, checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0 && n_req > 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// Watchdog sized from the number of requests
	initial begin
		wait (loaded);
		repeat ((n_req + 1) * CYCLES_PER_REQ + RST_CYCLES) @(posedge clk);
		$display("Watchdog expired, the run did not complete in time");
		$display("Finished with errors");
		$finish;
	end

endmodule

//--- bench/mem_system_input.txt
# op addr wdata expected_rdata expected_latency (hex except latency, in edges)
# op R read, W write, B read and write together (refused, latency 0)
R 0100 0000 0000 9
R 0102 0000 0000 2
W 0208 a5a5 a5a5 9
R 0208 0000 a5a5 2
W 020c 1234 1234 2
R 0208 0000 a5a5 2
R 020c 0000 1234 2
W 020e 0f0f 0f0f 2
R 0a08 0000 0000 13
R 0208 0000 a5a5 9
R 020c 0000 1234 2
R 020e 0000 0f0f 2
R 020a 0000 0000 2
B 0300 5555 0000 0
W 0300 5555 5555 9
W 8300 beef beef 13
R 0300 0000 5555 13
R 8300 0000 beef 9
B 8300 0000 0000 0
R 8302 0000 0000 2
W 8306 7777 7777 2
R 8306 0000 7777 2

//--- filelist.f
verilog/cache_pkg.sv
verilog/beat_counter.sv
verilog/cache_array.sv
verilog/main_memory.sv
verilog/cache_fsm.sv
verilog/mem_system.sv
bench/clock_gen.sv
bench/mem_system_asserts.sv
bench/mem_system_tb.sv
